/* verilog/zx_defs.svh */
`ifndef ZX_DEFS_SVH
`define ZX_DEFS_SVH

//////////////////////////////
// memory windows
//////////////////////////////

// 16k windows over the z80 address space
`define ZX_NUM_WIN 4

//////////////////////////////
// port codes, low address byte
//////////////////////////////

// border and beeper
`define ZX_PORT_FE 8'hFE

// covox level
`define ZX_PORT_FB 8'hFB

// atm window page, A15:A14 pick the window, A13 is rom/ram
`define ZX_PORT_F7 8'hF7

// 128k paging, only with A15 clear
`define ZX_PORT_7FFD_LO 8'hFD

// trdos entry, high byte of the M1 address
`define ZX_DOS_ENTRY_HI 8'h3D

// sound level bits
`define ZX_SND_W 8

`endif

/* verilog/zx_pkg.sv */
package zx_pkg;

	//////////////////////////////
	// z80 bus
	//////////////////////////////

	typedef logic [15:0] zaddr_t;
	typedef logic [7:0] zdata_t;

	//////////////////////////////
	// paging
	//////////////////////////////

	typedef logic [7:0] page_t;
	typedef logic [1:0] win_idx_t;
	typedef logic [4:0] rom_page_t;

	// ram: page & offset, rom: 3'b000 & rom page & offset
	typedef logic [21:0] mem_addr_t;

	// beeper / covox level
	typedef logic [7:0] snd_level_t;

	// port cycle fsm
	typedef enum logic [1:0] {
		io_idle,
		io_strobe,
		io_hold
	} io_state_t;

endpackage

/* verilog/zx_port_if.sv */
`timescale 1ns/10ps

interface zx_port_if;

	// one cycle per z80 write cycle
	logic wr_stb;

	// held from the start of the cycle until the next write
	zx_pkg::zaddr_t port_addr;
	zx_pkg::zdata_t wr_data;

	modport ctrl (
		output wr_stb,
		output port_addr,
		output wr_data
	);

	// pagers decode their own window writes
	modport pager (
		input wr_stb,
		input port_addr,
		input wr_data
	);

endinterface

/* verilog/port_ctrl.sv */
`timescale 1ns/10ps
`include "zx_defs.svh"

module port_ctrl (
	input  logic                                fclk,
	input  logic                                arst_n,
	input  zx_pkg::zaddr_t                      a,
	input  zx_pkg::zdata_t                      d_in,
	input  logic                                iorq_n,
	input  logic                                rd_n,
	input  logic                                wr_n,
	input  zx_pkg::page_t [`ZX_NUM_WIN-1:0]     win_page,
	input  logic [`ZX_NUM_WIN-1:0]              win_rom,
	output zx_pkg::zdata_t                      d_out,
	output logic                                d_oe,
	output zx_pkg::zdata_t                      p7ffd,
	output logic [2:0]                          border,
	output zx_pkg::snd_level_t                  snd_level,
	zx_port_if.ctrl                             bus
);
	import zx_pkg::*;

	io_state_t state;
	io_state_t state_nx;
	logic io_wr;
	logic io_rd;
	logic hit_7ffd;
	logic hit_fe;
	logic hit_fb;
	win_idx_t rd_win;

	assign io_wr = ~iorq_n & ~wr_n;
	assign io_rd = ~iorq_n & ~rd_n & (a[7:0] == `ZX_PORT_F7);

	//////////////////////////////
	// io write cycle
	//////////////////////////////

	always_comb
	begin
		state_nx = state;
		case (state)
			io_idle:   if (io_wr) state_nx = io_strobe;
			io_strobe: state_nx = io_hold;
			io_hold:   if (iorq_n) state_nx = io_idle;
			default:   state_nx = io_idle;
		endcase
	end

	always_ff @(posedge fclk or negedge arst_n)
	begin
		if (!arst_n)
			state <= io_idle;
		else
			state <= state_nx;
	end

	// address and data taken with the first sample of the strobes
	always_ff @(posedge fclk)
	begin
		if (state == io_idle && io_wr)
		begin
			bus.port_addr <= a;
			bus.wr_data   <= d_in;
		end
	end

	assign bus.wr_stb = (state == io_strobe);

	// port decode on the held address
	assign hit_7ffd  = ~bus.port_addr[15] && bus.port_addr[7:0] == `ZX_PORT_7FFD_LO;
	assign hit_fe    = bus.port_addr[7:0] == `ZX_PORT_FE;
	assign hit_fb    = bus.port_addr[7:0] == `ZX_PORT_FB;

	always_ff @(posedge fclk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			p7ffd     <= '0;
			border    <= '0;
			snd_level <= '0;
		end
		else if (bus.wr_stb)
		begin
			// bit 5 locks 7ffd until reset
			if (hit_7ffd && !p7ffd[5])
				p7ffd <= bus.wr_data;
			if (hit_fe)
			begin
				border    <= bus.wr_data[2:0];
				snd_level <= {$bits(snd_level_t){bus.wr_data[4]}};
			end
			if (hit_fb)
				snd_level <= bus.wr_data;
		end
	end

	//////////////////////////////
	// io read, xxF7 only
	//////////////////////////////

	assign rd_win = a[15:14];

	always_ff @(posedge fclk or negedge arst_n)
	begin
		if (!arst_n)
			d_oe <= 1'b0;
		else
			d_oe <= io_rd;
	end

	always_ff @(posedge fclk)
	begin
		if (io_rd)
			d_out <= win_page[rd_win];
	end

	// one strobe per write cycle
	a_single_stb: assert property (@(posedge fclk) disable iff (!arst_n)
		bus.wr_stb |=> !bus.wr_stb)
		else $error("wr_stb high in two consecutive cycles");

endmodule

/* verilog/window_pager.sv */
`timescale 1ns/10ps
`include "zx_defs.svh"

module window_pager #(
	parameter zx_pkg::win_idx_t WIN = '0
) (
	input  logic           fclk,
	input  logic           arst_n,
	zx_port_if.pager       bus,
	input  zx_pkg::zdata_t p7ffd,
	input  logic           dos,
	output zx_pkg::page_t  page,
	output logic           rom
);
	import zx_pkg::*;

	logic atm_mode;
	page_t atm_page;
	logic atm_rom;
	logic f7_hit;
	rom_page_t pent_rom_page;
	page_t pent_page;
	logic pent_rom;

	assign f7_hit = bus.wr_stb && bus.port_addr[7:0] == `ZX_PORT_F7
		&& bus.port_addr[15:14] == WIN;

	// once written, the window stays in atm mode until reset
	always_ff @(posedge fclk or negedge arst_n)
	begin
		if (!arst_n)
			atm_mode <= 1'b0;
		else if (f7_hit)
			atm_mode <= 1'b1;
	end

	always_ff @(posedge fclk)
	begin
		if (f7_hit)
		begin
			atm_page <= bus.wr_data;
			atm_rom  <= bus.port_addr[13];
		end
	end

	//////////////////////////////
	// pentagon mapping
	//////////////////////////////

	// dos and 7ffd bit 4 pick one of four roms
	assign pent_rom_page = {3'b000, dos, p7ffd[4]};

	always_comb
	begin
		case (WIN)
			2'd0:
			begin
				pent_page = {3'b000, pent_rom_page};
				pent_rom  = 1'b1;
			end
			2'd1:
			begin
				pent_page = 8'd5;
				pent_rom  = 1'b0;
			end
			2'd2:
			begin
				pent_page = 8'd2;
				pent_rom  = 1'b0;
			end
			default:
			begin
				pent_page = {5'b00000, p7ffd[2:0]};
				pent_rom  = 1'b0;
			end
		endcase
	end

	assign page = atm_mode ? atm_page : pent_page;
	assign rom  = atm_mode ? atm_rom : pent_rom;

endmodule

/* verilog/dos_ctrl.sv */
`timescale 1ns/10ps
`include "zx_defs.svh"

module dos_ctrl (
	input  logic           fclk,
	input  logic           arst_n,
	input  zx_pkg::zaddr_t a,
	input  logic           mreq_n,
	input  logic           m1_n,
	input  logic           rom0,
	input  zx_pkg::zdata_t p7ffd,
	output logic           dos
);
	import zx_pkg::*;

	logic fetch;
	logic fetch_s;
	logic fetch_q;
	logic fetch_start;
	zaddr_t fetch_a;
	logic enter;
	logic leave;

	assign fetch = ~mreq_n & ~m1_n;

	always_ff @(posedge fclk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			fetch_s <= 1'b0;
			fetch_q <= 1'b0;
		end
		else
		begin
			fetch_s <= fetch;
			fetch_q <= fetch_s;
		end
	end

	// opcode address at the first sample of the fetch
	always_ff @(posedge fclk)
	begin
		if (fetch && !fetch_s)
			fetch_a <= a;
	end

	assign fetch_start = fetch_s & ~fetch_q;

	// enter only from the basic48 rom, leave on any fetch above 4000
	assign enter = fetch_a[15:8] == `ZX_DOS_ENTRY_HI && rom0 && p7ffd[4];
	assign leave = fetch_a[15:14] != 2'b00;

	always_ff @(posedge fclk or negedge arst_n)
	begin
		if (!arst_n)
			dos <= 1'b0;
		else if (fetch_start)
		begin
			if (enter)
				dos <= 1'b1;
			else if (leave)
				dos <= 1'b0;
		end
	end

endmodule

/* verilog/mem_map.sv */
`timescale 1ns/10ps
`include "zx_defs.svh"

module mem_map (
	input  logic                            fclk,
	input  logic                            arst_n,
	input  zx_pkg::zaddr_t                  a,
	input  logic                            mreq_n,
	input  logic                            rd_n,
	input  logic                            m1_n,
	input  zx_pkg::page_t [`ZX_NUM_WIN-1:0] win_page,
	input  logic [`ZX_NUM_WIN-1:0]          win_rom,
	output zx_pkg::mem_addr_t               mem_addr,
	output logic                            ram_cs,
	output logic                            rom_cs
);
	import zx_pkg::*;

	logic mem_cyc;
	win_idx_t win;
	page_t sel_page;
	logic sel_rom;
	rom_page_t rom_pg;

	// read or opcode fetch, refresh has rd_n and m1_n both high
	assign mem_cyc = ~mreq_n & (~rd_n | ~m1_n);

	assign win      = a[15:14];
	assign sel_page = win_page[win];
	assign sel_rom  = win_rom[win];
	assign rom_pg   = sel_page[4:0];

	always_ff @(posedge fclk)
	begin
		if (sel_rom)
			mem_addr <= {3'b000, rom_pg, a[13:0]};
		else
			mem_addr <= {sel_page, a[13:0]};
	end

	always_ff @(posedge fclk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			ram_cs <= 1'b0;
			rom_cs <= 1'b0;
		end
		else
		begin
			ram_cs <= mem_cyc & ~sel_rom;
			rom_cs <= mem_cyc & sel_rom;
		end
	end

	a_one_cs: assert property (@(posedge fclk) disable iff (!arst_n)
		!(ram_cs && rom_cs))
		else $error("ram_cs and rom_cs both active");

endmodule

/* verilog/sound_dsm.sv */
`timescale 1ns/10ps
`include "zx_defs.svh"

module sound_dsm (
	input  logic               fclk,
	input  logic               arst_n,
	input  zx_pkg::snd_level_t level,
	output logic               beep
);
	import zx_pkg::*;

	// carry bit on top of the level width
	logic [`ZX_SND_W:0] acc;
	logic [`ZX_SND_W:0] acc_nx;

	// residue plus level, the carry is the output bit
	assign acc_nx = {1'b0, acc[`ZX_SND_W-1:0]} + {1'b0, level};

	always_ff @(posedge fclk or negedge arst_n)
	begin
		if (!arst_n)
			acc <= '0;
		else
			acc <= acc_nx;
	end

	// L carries in every 2^ZX_SND_W cycles for a steady level
	assign beep = acc[`ZX_SND_W];

endmodule

/* verilog/zx_mapper.sv */
`timescale 1ns/10ps
`include "zx_defs.svh"

module zx_mapper (
	input  logic              fclk,
	input  logic              arst_n,
	input  zx_pkg::zaddr_t    a,
	input  zx_pkg::zdata_t    d_in,
	output zx_pkg::zdata_t    d_out,
	output logic              d_oe,
	input  logic              iorq_n,
	input  logic              mreq_n,
	input  logic              m1_n,
	input  logic              rd_n,
	input  logic              wr_n,
	output zx_pkg::mem_addr_t mem_addr,
	output logic              ram_cs,
	output logic              rom_cs,
	output logic [2:0]        border,
	output logic              beep
);
	import zx_pkg::*;

	page_t [`ZX_NUM_WIN-1:0] win_page;
	logic [`ZX_NUM_WIN-1:0] win_rom;
	zdata_t p7ffd;
	snd_level_t snd_level;
	logic dos;

	zx_port_if port_bus ();

	//////////////////////////////
	// ports
	//////////////////////////////

	port_ctrl u_port_ctrl (
		.fclk      (fclk),
		.arst_n    (arst_n),
		.a         (a),
		.d_in      (d_in),
		.iorq_n    (iorq_n),
		.rd_n      (rd_n),
		.wr_n      (wr_n),
		.win_page  (win_page),
		.win_rom   (win_rom),
		.d_out     (d_out),
		.d_oe      (d_oe),
		.p7ffd     (p7ffd),
		.border    (border),
		.snd_level (snd_level),
		.bus       (port_bus.ctrl)
	);

	//////////////////////////////
	// paging
	//////////////////////////////

	for (genvar i = 0; i < `ZX_NUM_WIN; i++)
	begin : g_pager
		window_pager #(
			.WIN (win_idx_t'(i))
		) u_pager (
			.fclk   (fclk),
			.arst_n (arst_n),
			.bus    (port_bus.pager),
			.p7ffd  (p7ffd),
			.dos    (dos),
			.page   (win_page[i]),
			.rom    (win_rom[i])
		);
	end

	dos_ctrl u_dos_ctrl (
		.fclk   (fclk),
		.arst_n (arst_n),
		.a      (a),
		.mreq_n (mreq_n),
		.m1_n   (m1_n),
		.rom0   (win_rom[0]),
		.p7ffd  (p7ffd),
		.dos    (dos)
	);

	mem_map u_mem_map (
		.fclk     (fclk),
		.arst_n   (arst_n),
		.a        (a),
		.mreq_n   (mreq_n),
		.rd_n     (rd_n),
		.m1_n     (m1_n),
		.win_page (win_page),
		.win_rom  (win_rom),
		.mem_addr (mem_addr),
		.ram_cs   (ram_cs),
		.rom_cs   (rom_cs)
	);

	// beeper and covox
	sound_dsm u_sound (
		.fclk   (fclk),
		.arst_n (arst_n),
		.level  (snd_level),
		.beep   (beep)
	);

endmodule

/* test/tb_zx_mapper.sv */
`timescale 1ns/10ps

module tb_zx_mapper;

	logic        fclk;
	logic        arst_n;
	logic [15:0] a;
	logic [7:0]  d_in;
	logic [7:0]  d_out;
	logic        d_oe;
	logic        iorq_n;
	logic        mreq_n;
	logic        m1_n;
	logic        rd_n;
	logic        wr_n;
	logic [21:0] mem_addr;
	logic        ram_cs;
	logic        rom_cs;
	logic [2:0]  border;
	logic        beep;

	// model of the paging state
	logic [7:0]  m_7ffd;
	logic        m_dos;
	logic [3:0]  m_atm;
	logic [7:0]  m_page [4];
	logic [3:0]  m_rom;
	logic [7:0]  m_level;
	logic [2:0]  m_border;

	logic [15:0] lfsr;
	logic        mem_chk;
	logic [15:0] mem_a;
	logic [23:0] exp_map;
	int          num_checks;
	int          num_errors;
	int          err_mark;
	int          cycles;

	zx_mapper DUT (.*);

	initial
	begin
		fclk = 1'b0;
		forever #10 fclk = ~fclk;
	end

	//////////////////////////////
	// reference model
	//////////////////////////////

	// {rom, page} of one window
	function automatic logic [8:0] model_win(input logic [1:0] w);
		logic [7:0] pg;
		logic       rom;
		if (m_atm[w])
		begin
			pg  = m_page[w];
			rom = m_rom[w];
		end
		else
		begin
			rom = (w == 2'd0);
			case (w)
				2'd0:    pg = {6'd0, m_dos, m_7ffd[4]};
				2'd1:    pg = 8'd5;
				2'd2:    pg = 8'd2;
				default: pg = {5'd0, m_7ffd[2:0]};
			endcase
		end
		return {rom, pg};
	endfunction

	// {rom_cs, ram_cs, mem_addr} for a read at addr
	function automatic logic [23:0] ref_map(input logic [15:0] addr);
		logic [8:0] wp;
		wp = model_win(addr[15:14]);
		if (wp[8])
			return {2'b10, 3'b000, wp[4:0], addr[13:0]};
		return {2'b01, wp[7:0], addr[13:0]};
	endfunction

	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic rand_byte(output logic [7:0] v);
		for (int i = 0; i < 8; i++)
		begin
			lfsr = lfsr_next(lfsr);
			v = {v[6:0], lfsr[0]};
		end
	endtask

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		num_checks++;
		if (got !== exp)
		begin
			num_errors++;
			$display("** Error at %0t: %s = %0h, expected %0h", $time, name, got, exp);
		end
	endtask

	//////////////////////////////
	// bus cycles
	//////////////////////////////

	task automatic do_reset;
		arst_n <= 1'b0;
		repeat (10) @(posedge fclk);
		arst_n <= 1'b1;
		m_7ffd = '0;
		m_dos = 1'b0;
		m_atm = '0;
		m_rom = '0;
		m_level = '0;
		m_border = '0;
		@(posedge fclk);
	endtask

	task automatic io_write(input logic [15:0] addr, input logic [7:0] data);
		a <= addr;
		d_in <= data;
		iorq_n <= 1'b0;
		wr_n <= 1'b0;
		repeat (3) @(posedge fclk);
		iorq_n <= 1'b1;
		wr_n <= 1'b1;
		if (addr[7:0] == 8'hFD && !addr[15] && !m_7ffd[5])
			m_7ffd = data;
		if (addr[7:0] == 8'hFE)
		begin
			m_border = data[2:0];
			m_level = data[4] ? 8'hFF : 8'h00;
		end
		if (addr[7:0] == 8'hFB)
			m_level = data;
		if (addr[7:0] == 8'hF7)
		begin
			m_atm[addr[15:14]] = 1'b1;
			m_page[addr[15:14]] = data;
			m_rom[addr[15:14]] = addr[13];
		end
		@(posedge fclk);
	endtask

	task automatic io_read(input logic [15:0] addr);
		logic [8:0] wp;
		wp = model_win(addr[15:14]);
		a <= addr;
		iorq_n <= 1'b0;
		rd_n <= 1'b0;
		@(posedge fclk);
		@(negedge fclk);
		check("d_oe", 32'(d_oe), 32'(addr[7:0] == 8'hF7));
		if (addr[7:0] == 8'hF7)
			check("d_out", 32'(d_out), 32'(wp[7:0]));
		repeat (2) @(posedge fclk);
		iorq_n <= 1'b1;
		rd_n <= 1'b1;
		@(posedge fclk);
		@(negedge fclk);
		check("d_oe after read", 32'(d_oe), 32'd0);
		@(posedge fclk);
	endtask

	// the comparing process checks the first sample of the cycle
	task automatic mem_access(input logic [15:0] addr, input logic m1);
		a <= addr;
		mem_a = addr;
		mreq_n <= 1'b0;
		rd_n <= 1'b0;
		m1_n <= !m1;
		@(posedge fclk);
		mem_chk <= 1'b1;
		@(posedge fclk);
		mem_chk <= 1'b0;
		@(posedge fclk);
		mreq_n <= 1'b1;
		rd_n <= 1'b1;
		m1_n <= 1'b1;
		if (m1)
		begin
			if (addr[15:8] == 8'h3D && model_win(2'd0) >> 8 && m_7ffd[4])
				m_dos = 1'b1;
			else if (addr[15:14] != 2'b00)
				m_dos = 1'b0;
		end
		@(posedge fclk);
	endtask

	task automatic count_beep;
		int ones;
		ones = 0;
		repeat (2) @(posedge fclk);
		repeat (256)
		begin
			@(negedge fclk);
			ones = ones + 32'(beep);
		end
		check("beep ones", 32'(ones), 32'(m_level));
		@(posedge fclk);
	endtask

	task automatic end_test(input string name);
		$display("%s: done, %0d errors", name, num_errors - err_mark);
		err_mark = num_errors;
	endtask

	always @(negedge fclk)
	begin
		if (mem_chk)
		begin
			exp_map = ref_map(mem_a);
			check("mem_addr", 32'(mem_addr), 32'(exp_map[21:0]));
			check("rom_cs", 32'(rom_cs), 32'(exp_map[23]));
			check("ram_cs", 32'(ram_cs), 32'(exp_map[22]));
		end
	end

	// about twice the length of all tests
	always @(posedge fclk)
	begin
		cycles++;
		if (cycles == 3000)
		begin
			$display("timeout: tests did not finish within %0d cycles", cycles);
			$display("TEST FAILED");
			$finish;
		end
	end

	//////////////////////////////
	// tests
	//////////////////////////////

	initial
	begin
		logic [7:0] v;
		logic [7:0] sel;
		arst_n = 1'b0;
		a = '0;
		d_in = '0;
		iorq_n = 1'b1;
		mreq_n = 1'b1;
		m1_n = 1'b1;
		rd_n = 1'b1;
		wr_n = 1'b1;
		mem_chk = 1'b0;
		mem_a = '0;
		lfsr = 16'd73;
		num_checks = 0;
		num_errors = 0;
		err_mark = 0;
		cycles = 0;

		do_reset;
		@(negedge fclk);
		check("d_oe", 32'(d_oe), 32'd0);
		check("ram_cs", 32'(ram_cs), 32'd0);
		check("rom_cs", 32'(rom_cs), 32'd0);
		@(posedge fclk);
		for (int w = 0; w < 4; w++)
			mem_access({w[1:0], 14'h1A5C}, 1'b0);
		end_test("reset mapping");

		do_reset;
		for (int i = 0; i < 6; i++)
		begin
			rand_byte(v);
			v[5] = 1'b0;
			// A15 set is not 7ffd
			io_write((i == 3) ? 16'hFFFD : 16'h7FFD, v);
			mem_access(16'h0042, 1'b0);
			mem_access(16'hC042, 1'b0);
		end
		rand_byte(v);
		v[5] = 1'b1;
		io_write(16'h7FFD, v);
		mem_access(16'h0042, 1'b0);
		mem_access(16'hC042, 1'b0);
		io_write(16'h7FFD, v ^ 8'h17);
		mem_access(16'h0042, 1'b0);
		mem_access(16'hC042, 1'b0);
		end_test("7ffd paging and lock");

		do_reset;
		for (int i = 0; i < 6; i++)
		begin
			rand_byte(v);
			rand_byte(sel);
			io_write({sel[1:0], sel[2], 5'd0, 8'hF7}, v);
			for (int w = 0; w < 4; w++)
				mem_access({w[1:0], 14'h2301}, 1'b0);
		end
		for (int w = 0; w < 4; w++)
			io_read({w[1:0], 6'd0, 8'hF7});
		io_read(16'h7FFD);
		io_read(16'h40FE);
		end_test("atm windows");

		do_reset;
		io_write(16'h7FFD, 8'h10);
		mem_access(16'h0100, 1'b0);
		mem_access(16'h3D2F, 1'b1);
		mem_access(16'h0100, 1'b0);
		mem_access(16'h8000, 1'b1);
		mem_access(16'h0100, 1'b0);
		end_test("dos entry and exit");

		do_reset;
		for (int i = 0; i < 3; i++)
		begin
			rand_byte(v);
			io_write(16'h12FB, v);
			count_beep;
		end
		for (int i = 0; i < 2; i++)
		begin
			rand_byte(v);
			v[4] = (i == 0);
			io_write(16'h00FE, v);
			@(negedge fclk);
			check("border", 32'(border), 32'(m_border));
			@(posedge fclk);
			count_beep;
		end
		end_test("sound");

		$display("checks %0d, errors %0d", num_checks, num_errors);
		if (num_errors == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

/* filelist.f */
+incdir+verilog
verilog/zx_pkg.sv
verilog/zx_port_if.sv
verilog/port_ctrl.sv
verilog/window_pager.sv
verilog/dos_ctrl.sv
verilog/mem_map.sv
verilog/sound_dsm.sv
verilog/zx_mapper.sv
test/tb_zx_mapper.sv

/* run.sh */
#!/bin/sh
# build and run the zx_mapper testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
	--top-module tb_zx_mapper \
	-f filelist.f \
	-o sim_zx_mapper

./obj_dir/sim_zx_mapper > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST FAILED" sim.log; then
	echo "simulation reported failure"
	exit 1
fi
echo "simulation finished without failure"
